// ==== src/cpu_settings.svh ====
////////////////////////////////////////////////////////////////////////////
// width and depth macros for the five-stage ARM-subset core
// register file size, link register index, memory index widths
////////////////////////////////////////////////////////////////////////////
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data path and address width
`define CPU_XLEN 32

// register file geometry
`define CPU_REG_AW 4
`define CPU_NREGS (1 << `CPU_REG_AW)

// BL writes its return address here
`define CPU_LINK_REG 14

// instruction memory, indexed by pc[7:2]
`define CPU_IMEM_AW 6
`define CPU_IMEM_DEPTH (1 << `CPU_IMEM_AW)

// data memory, indexed by addr[6:2]
`define CPU_DMEM_AW 5
`define CPU_DMEM_DEPTH (1 << `CPU_DMEM_AW)

`endif

// ==== src/cpu_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// shared types of the core
// instruction word views, ALU op codes, control bundle, writeback bundle
////////////////////////////////////////////////////////////////////////////
`include "cpu_settings.svh"

package cpu_pkg;

  // data processing, class 00
  typedef struct packed {
    logic [3:0]             cond;
    logic [1:0]             cls;
    logic                   imm_flag;
    logic [3:0]             opcode;
    logic                   s_bit;
    logic [`CPU_REG_AW-1:0] rn;
    logic [`CPU_REG_AW-1:0] rd;
    // imm8 in [7:0], rm in [3:0]
    logic [11:0]            operand;
  } dp_t;

  // single word load/store, class 01
  typedef struct packed {
    logic [3:0]             cond;
    logic [1:0]             cls;
    logic [4:0]             unused;
    logic                   load;
    logic [`CPU_REG_AW-1:0] rn;
    logic [`CPU_REG_AW-1:0] rd;
    logic [11:0]            imm12;
  } mem_t;

  // branch, class 101
  typedef struct packed {
    logic [3:0]  cond;
    logic [2:0]  cls;
    logic        link;
    logic [23:0] offset;
  } br_t;

  // one fetched word, decoded through whichever view matches its class
  typedef union packed {
    dp_t  dp;
    mem_t mem;
    br_t  br;
  } inst_u;

  typedef enum logic [3:0] {
    ALU_AND = 4'b0000,
    ALU_EOR = 4'b0001,
    ALU_SUB = 4'b0010,
    ALU_RSB = 4'b0011,
    ALU_ADD = 4'b0100,
    ALU_ORR = 4'b1100,
    ALU_MOV = 4'b1101,
    ALU_BIC = 4'b1110,
    ALU_MVN = 4'b1111
  } alu_op_e;

  // per-instruction control, all zero for a bubble
  typedef struct packed {
    logic    reg_wen;
    logic    load;
    logic    store;
    logic    use_imm;
    logic    branch;
    logic    link;
    alu_op_e alu_op;
  } ctrl_t;

  // register write: forward path, writeback port and trace
  typedef struct packed {
    logic                   valid;
    logic [`CPU_REG_AW-1:0] addr;
    logic [`CPU_XLEN-1:0]   data;
  } wb_t;

endpackage

// ==== src/cpu_alu.sv ====
////////////////////////////////////////////////////////////////////////////
// combinational ALU, nine ops, carry and overflow out
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_alu (
  input  logic [`CPU_XLEN-1:0] a_i,
  input  logic [`CPU_XLEN-1:0] b_i,
  input  cpu_pkg::alu_op_e     op_i,
  output logic [`CPU_XLEN-1:0] result_o,
  output logic                 carry_o,
  output logic                 overflow_o
);

  logic                 arith;
  logic [`CPU_XLEN-1:0] add_x;
  logic [`CPU_XLEN-1:0] add_y;
  logic                 add_cin;
  logic [`CPU_XLEN:0]   sum;

  // one adder: sub is a + ~b + 1, rsb is b + ~a + 1
  always_comb begin
    arith   = 1'b0;
    add_x   = a_i;
    add_y   = b_i;
    add_cin = 1'b0;
    case (op_i)
      cpu_pkg::ALU_ADD: arith = 1'b1;
      cpu_pkg::ALU_SUB: begin
        arith   = 1'b1;
        add_y   = ~b_i;
        add_cin = 1'b1;
      end
      cpu_pkg::ALU_RSB: begin
        arith   = 1'b1;
        add_x   = b_i;
        add_y   = ~a_i;
        add_cin = 1'b1;
      end
      default: arith = 1'b0;
    endcase
  end

  assign sum = {1'b0, add_x} + {1'b0, add_y} + {{`CPU_XLEN{1'b0}}, add_cin};

  always_comb begin
    case (op_i)
      cpu_pkg::ALU_AND: result_o = a_i & b_i;
      cpu_pkg::ALU_EOR: result_o = a_i ^ b_i;
      cpu_pkg::ALU_ORR: result_o = a_i | b_i;
      cpu_pkg::ALU_MOV: result_o = b_i;
      cpu_pkg::ALU_BIC: result_o = a_i & ~b_i;
      cpu_pkg::ALU_MVN: result_o = ~b_i;
      cpu_pkg::ALU_ADD,
      cpu_pkg::ALU_SUB,
      cpu_pkg::ALU_RSB: result_o = sum[`CPU_XLEN-1:0];
      // unassigned codes pass operand one
      default:          result_o = a_i;
    endcase
  end

  // carry out doubles as no-borrow for the subtracts
  assign carry_o    = arith & sum[`CPU_XLEN];
  // adder inputs agree in sign but the sum does not
  assign overflow_o = arith & (add_x[`CPU_XLEN-1] == add_y[`CPU_XLEN-1]) &
                      (sum[`CPU_XLEN-1] != add_x[`CPU_XLEN-1]);

endmodule

// ==== src/cpu_regfile.sv ====
////////////////////////////////////////////////////////////////////////////
// register file, 16 x 32, two async reads, one write, write-through
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_regfile (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic [`CPU_REG_AW-1:0] rd_addr1_i,
  input  logic [`CPU_REG_AW-1:0] rd_addr2_i,
  input  cpu_pkg::wb_t           wb_i,
  output logic [`CPU_XLEN-1:0]   rd_data1_o,
  output logic [`CPU_XLEN-1:0]   rd_data2_o
);

  logic [`CPU_XLEN-1:0] regs [0:`CPU_NREGS-1];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.valid) begin
      regs[wb_i.addr] <= wb_i.data;
    end
  end

  // a write landing this cycle is visible to decode right away
  assign rd_data1_o = (wb_i.valid && wb_i.addr == rd_addr1_i) ? wb_i.data : regs[rd_addr1_i];
  assign rd_data2_o = (wb_i.valid && wb_i.addr == rd_addr2_i) ? wb_i.data : regs[rd_addr2_i];

endmodule

// ==== src/cpu_fetch.sv ====
////////////////////////////////////////////////////////////////////////////
// fetch stage
// program counter, writable instruction memory, fetch-to-decode register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_fetch (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    imem_we_i,
  input  logic [`CPU_IMEM_AW-1:0] imem_addr_i,
  input  logic [`CPU_XLEN-1:0]    imem_data_i,
  input  logic                    redirect_i,
  input  logic [`CPU_XLEN-1:0]    target_i,
  output cpu_pkg::inst_u          inst_o,
  output logic [`CPU_XLEN-1:0]    pc_o
);

  // branch with cond NV, decodes as a harmless bubble
  localparam logic [`CPU_XLEN-1:0] NOP_WORD = 32'hfa00_0000;

  logic [`CPU_XLEN-1:0] imem [0:`CPU_IMEM_DEPTH-1];
  logic [`CPU_XLEN-1:0] pc;
  logic [`CPU_XLEN-1:0] pc_next;

  // loaded by the testbench while the core sits in reset
  always_ff @(posedge clk) begin
    if (imem_we_i) begin
      imem[imem_addr_i] <= imem_data_i;
    end
  end

  // taken branch in execute overrides sequential fetch
  assign pc_next = redirect_i ? target_i : pc + `CPU_XLEN'(4);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  // word index from pc[7:2]
  always_ff @(posedge clk) begin
    if (!resetn) begin
      inst_o <= NOP_WORD;
      pc_o   <= '0;
    end else begin
      inst_o <= imem[pc[`CPU_IMEM_AW+1:2]];
      pc_o   <= pc;
    end
  end

endmodule

// ==== src/cpu_decode.sv ====
////////////////////////////////////////////////////////////////////////////
// decode stage
// control decode, immediate extension, register read,
// decode-to-execute register with annul
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_decode (
  input  logic                 clk,
  input  logic                 resetn,
  input  cpu_pkg::inst_u       inst_i,
  input  logic [`CPU_XLEN-1:0] pc_i,
  input  logic                 annul_i,
  input  cpu_pkg::wb_t         wb_i,
  output cpu_pkg::ctrl_t       ctrl_o,
  output logic [`CPU_XLEN-1:0] rs1_data_o,
  output logic [`CPU_XLEN-1:0] rs2_data_o,
  output logic [`CPU_XLEN-1:0] imm_o,
  output cpu_pkg::inst_u       inst_o,
  output logic [`CPU_XLEN-1:0] pc_o
);

  cpu_pkg::ctrl_t         ctrl_d;
  logic [`CPU_XLEN-1:0]   imm_d;
  logic [`CPU_REG_AW-1:0] rs2_addr;
  logic [`CPU_XLEN-1:0]   rs1_d;
  logic [`CPU_XLEN-1:0]   rs2_d;

  //////////////////////////////////////////////////////////////////////////
  // control decode
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl_d        = '0;
    // address generation and link use the adder
    ctrl_d.alu_op = cpu_pkg::ALU_ADD;
    if (inst_i.dp.cls == 2'b00) begin
      ctrl_d.reg_wen = 1'b1;
      ctrl_d.use_imm = inst_i.dp.imm_flag;
      ctrl_d.alu_op  = cpu_pkg::alu_op_e'(inst_i.dp.opcode);
    end else if (inst_i.mem.cls == 2'b01) begin
      ctrl_d.load    = inst_i.mem.load;
      ctrl_d.store   = ~inst_i.mem.load;
      ctrl_d.reg_wen = inst_i.mem.load;
      ctrl_d.use_imm = 1'b1;
    end else if (inst_i.br.cls == 3'b101) begin
      ctrl_d.branch  = 1'b1;
      ctrl_d.link    = inst_i.br.link;
      ctrl_d.reg_wen = inst_i.br.link;
    end
  end

  // imm12 for load/store, imm8 otherwise, both sign extended
  assign imm_d = (inst_i.mem.cls == 2'b01) ?
                 {{(`CPU_XLEN-12){inst_i.mem.imm12[11]}}, inst_i.mem.imm12} :
                 {{(`CPU_XLEN-8){inst_i.dp.operand[7]}}, inst_i.dp.operand[7:0]};

  // second port reads rd for store data, rm otherwise
  assign rs2_addr = ctrl_d.store ? inst_i.mem.rd : inst_i.dp.operand[3:0];

  cpu_regfile u_regfile (
    .clk        (clk),
    .resetn     (resetn),
    .rd_addr1_i (inst_i.dp.rn),
    .rd_addr2_i (rs2_addr),
    .wb_i       (wb_i),
    .rd_data1_o (rs1_d),
    .rd_data2_o (rs2_d)
  );

  //////////////////////////////////////////////////////////////////////////
  // decode-to-execute register
  //////////////////////////////////////////////////////////////////////////

  // annul turns the slot behind a taken branch into a bubble
  always_ff @(posedge clk) begin
    if (!resetn || annul_i) begin
      ctrl_o <= '0;
    end else begin
      ctrl_o <= ctrl_d;
    end
  end

  always_ff @(posedge clk) begin
    rs1_data_o <= rs1_d;
    rs2_data_o <= rs2_d;
    imm_o      <= imm_d;
    inst_o     <= inst_i;
    pc_o       <= pc_i;
  end

endmodule

// ==== src/cpu_execute.sv ====
////////////////////////////////////////////////////////////////////////////
// execute stage
// operand forwarding, ALU, NZCV flags, branch resolve and annul,
// execute-to-memory register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_execute (
  input  logic                   clk,
  input  logic                   resetn,
  input  cpu_pkg::ctrl_t         ctrl_i,
  input  logic [`CPU_XLEN-1:0]   rs1_data_i,
  input  logic [`CPU_XLEN-1:0]   rs2_data_i,
  input  logic [`CPU_XLEN-1:0]   imm_i,
  input  cpu_pkg::inst_u         inst_i,
  input  logic [`CPU_XLEN-1:0]   pc_i,
  input  cpu_pkg::wb_t           fwd_m_i,
  input  cpu_pkg::wb_t           fwd_w_i,
  output logic                   redirect_o,
  output logic [`CPU_XLEN-1:0]   target_o,
  output logic                   annul_o,
  output cpu_pkg::ctrl_t         ctrl_o,
  output logic [`CPU_XLEN-1:0]   result_o,
  output logic [`CPU_XLEN-1:0]   store_data_o,
  output logic [`CPU_REG_AW-1:0] rd_o,
  output logic [`CPU_XLEN-1:0]   pc_o
);

  // memory stage is younger, so it wins over writeback
  function automatic logic [`CPU_XLEN-1:0] pick_operand(
    input logic [`CPU_REG_AW-1:0] src,
    input logic [`CPU_XLEN-1:0]   reg_val,
    input cpu_pkg::wb_t           m_stage,
    input cpu_pkg::wb_t           w_stage
  );
    logic [`CPU_XLEN-1:0] val;
    if (m_stage.valid && m_stage.addr == src) begin
      val = m_stage.data;
    end else if (w_stage.valid && w_stage.addr == src) begin
      val = w_stage.data;
    end else begin
      val = reg_val;
    end
    return val;
  endfunction

  logic [`CPU_REG_AW-1:0] rs2_addr;
  logic [`CPU_XLEN-1:0]   op_a;
  logic [`CPU_XLEN-1:0]   op_reg_b;
  logic [`CPU_XLEN-1:0]   op_b;
  logic [`CPU_XLEN-1:0]   alu_res;
  logic                   alu_carry;
  logic                   alu_ovf;
  logic                   flag_n;
  logic                   flag_z;
  logic                   flag_c;
  logic                   flag_v;
  logic                   cond_ok;
  logic                   taken;
  logic                   annul_q;

  // same index choice as the decode read port
  assign rs2_addr = ctrl_i.store ? inst_i.mem.rd : inst_i.dp.operand[3:0];
  assign op_a     = pick_operand(inst_i.dp.rn, rs1_data_i, fwd_m_i, fwd_w_i);
  assign op_reg_b = pick_operand(rs2_addr, rs2_data_i, fwd_m_i, fwd_w_i);
  assign op_b     = ctrl_i.use_imm ? imm_i : op_reg_b;

  cpu_alu u_alu (
    .a_i        (op_a),
    .b_i        (op_b),
    .op_i       (ctrl_i.alu_op),
    .result_o   (alu_res),
    .carry_o    (alu_carry),
    .overflow_o (alu_ovf)
  );

  //////////////////////////////////////////////////////////////////////////
  // flags and branch
  //////////////////////////////////////////////////////////////////////////

  // every data-processing op sets NZCV, bubbles never do
  always_ff @(posedge clk) begin
    if (!resetn) begin
      flag_n <= 1'b0;
      flag_z <= 1'b0;
      flag_c <= 1'b0;
      flag_v <= 1'b0;
    end else if (ctrl_i.reg_wen && !ctrl_i.load && !ctrl_i.link) begin
      flag_n <= alu_res[`CPU_XLEN-1];
      flag_z <= (alu_res == '0);
      flag_c <= alu_carry;
      flag_v <= alu_ovf;
    end
  end

  // ARM condition table
  always_comb begin
    case (inst_i.br.cond)
      4'b0000: cond_ok = flag_z;
      4'b0001: cond_ok = ~flag_z;
      4'b0010: cond_ok = flag_c;
      4'b0011: cond_ok = ~flag_c;
      4'b0100: cond_ok = flag_n;
      4'b0101: cond_ok = ~flag_n;
      4'b0110: cond_ok = flag_v;
      4'b0111: cond_ok = ~flag_v;
      4'b1000: cond_ok = flag_c & ~flag_z;
      4'b1001: cond_ok = ~flag_c | flag_z;
      4'b1010: cond_ok = (flag_n == flag_v);
      4'b1011: cond_ok = (flag_n != flag_v);
      4'b1100: cond_ok = ~flag_z & (flag_n == flag_v);
      4'b1101: cond_ok = flag_z | (flag_n != flag_v);
      4'b1110: cond_ok = 1'b1;
      default: cond_ok = 1'b0;
    endcase
  end

  assign taken      = ctrl_i.branch & cond_ok;
  assign redirect_o = taken;
  // branch address plus offset words, offset 0 spins in place
  assign target_o   = pc_i + {{(`CPU_XLEN-26){inst_i.br.offset[23]}}, inst_i.br.offset, 2'b00};

  // kill the two wrong-path slots, now and next cycle
  always_ff @(posedge clk) begin
    if (!resetn) begin
      annul_q <= 1'b0;
    end else begin
      annul_q <= taken;
    end
  end

  assign annul_o = taken | annul_q;

  //////////////////////////////////////////////////////////////////////////
  // execute-to-memory register
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ctrl_o <= '0;
    end else begin
      ctrl_o <= ctrl_i;
    end
  end

  always_ff @(posedge clk) begin
    result_o     <= alu_res;
    store_data_o <= op_reg_b;
    rd_o         <= ctrl_i.link ? `CPU_REG_AW'(`CPU_LINK_REG) : inst_i.dp.rd;
    pc_o         <= pc_i;
  end

endmodule

// ==== src/cpu_memory.sv ====
////////////////////////////////////////////////////////////////////////////
// memory stage
// data memory, stage result select, memory-to-writeback register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_memory (
  input  logic                   clk,
  input  logic                   resetn,
  input  cpu_pkg::ctrl_t         ctrl_i,
  input  logic [`CPU_XLEN-1:0]   result_i,
  input  logic [`CPU_XLEN-1:0]   store_data_i,
  input  logic [`CPU_REG_AW-1:0] rd_i,
  input  logic [`CPU_XLEN-1:0]   pc_i,
  output cpu_pkg::wb_t           fwd_m_o,
  output cpu_pkg::wb_t           wb_o
);

  logic [`CPU_XLEN-1:0]   dmem [0:`CPU_DMEM_DEPTH-1];
  logic [`CPU_DMEM_AW-1:0] dmem_idx;
  logic [`CPU_XLEN-1:0]   load_data;
  logic [`CPU_XLEN-1:0]   stage_res;

  // word index from address bits 6:2
  assign dmem_idx  = result_i[`CPU_DMEM_AW+1:2];
  assign load_data = dmem[dmem_idx];

  always_ff @(posedge clk) begin
    if (ctrl_i.store) begin
      dmem[dmem_idx] <= store_data_i;
    end
  end

  // load data, return address for BL, or the ALU value
  assign stage_res = ctrl_i.load ? load_data :
                     ctrl_i.link ? pc_i + `CPU_XLEN'(4) :
                     result_i;

  // also the forward source for the instruction now in execute
  assign fwd_m_o.valid = ctrl_i.reg_wen;
  assign fwd_m_o.addr  = rd_i;
  assign fwd_m_o.data  = stage_res;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      wb_o.valid <= 1'b0;
    end else begin
      wb_o.valid <= fwd_m_o.valid;
    end
  end

  always_ff @(posedge clk) begin
    wb_o.addr <= fwd_m_o.addr;
    wb_o.data <= fwd_m_o.data;
  end

endmodule

// ==== src/cpu.sv ====
////////////////////////////////////////////////////////////////////////////
// top of the five-stage core
// fetch, decode, execute, memory; writeback exposed as a trace port
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    imem_we_i,
  input  logic [`CPU_IMEM_AW-1:0] imem_addr_i,
  input  logic [`CPU_XLEN-1:0]    imem_data_i,
  output cpu_pkg::wb_t            wb_o
);

  // fetch to decode
  cpu_pkg::inst_u       inst_d;
  logic [`CPU_XLEN-1:0] pc_d;

  // decode to execute
  cpu_pkg::ctrl_t       ctrl_x;
  logic [`CPU_XLEN-1:0] rs1_x;
  logic [`CPU_XLEN-1:0] rs2_x;
  logic [`CPU_XLEN-1:0] imm_x;
  cpu_pkg::inst_u       inst_x;
  logic [`CPU_XLEN-1:0] pc_x;

  // execute to memory, plus redirect back to the front
  logic                   redirect;
  logic [`CPU_XLEN-1:0]   target;
  logic                   annul;
  cpu_pkg::ctrl_t         ctrl_m;
  logic [`CPU_XLEN-1:0]   result_m;
  logic [`CPU_XLEN-1:0]   store_data_m;
  logic [`CPU_REG_AW-1:0] rd_m;
  logic [`CPU_XLEN-1:0]   pc_m;

  // forward and writeback paths
  cpu_pkg::wb_t fwd_m;
  cpu_pkg::wb_t wb;

  cpu_fetch u_fetch (
    .clk         (clk),
    .resetn      (resetn),
    .imem_we_i   (imem_we_i),
    .imem_addr_i (imem_addr_i),
    .imem_data_i (imem_data_i),
    .redirect_i  (redirect),
    .target_i    (target),
    .inst_o      (inst_d),
    .pc_o        (pc_d)
  );

  cpu_decode u_decode (
    .clk        (clk),
    .resetn     (resetn),
    .inst_i     (inst_d),
    .pc_i       (pc_d),
    .annul_i    (annul),
    .wb_i       (wb),
    .ctrl_o     (ctrl_x),
    .rs1_data_o (rs1_x),
    .rs2_data_o (rs2_x),
    .imm_o      (imm_x),
    .inst_o     (inst_x),
    .pc_o       (pc_x)
  );

  cpu_execute u_execute (
    .clk          (clk),
    .resetn       (resetn),
    .ctrl_i       (ctrl_x),
    .rs1_data_i   (rs1_x),
    .rs2_data_i   (rs2_x),
    .imm_i        (imm_x),
    .inst_i       (inst_x),
    .pc_i         (pc_x),
    .fwd_m_i      (fwd_m),
    .fwd_w_i      (wb),
    .redirect_o   (redirect),
    .target_o     (target),
    .annul_o      (annul),
    .ctrl_o       (ctrl_m),
    .result_o     (result_m),
    .store_data_o (store_data_m),
    .rd_o         (rd_m),
    .pc_o         (pc_m)
  );

  cpu_memory u_memory (
    .clk          (clk),
    .resetn       (resetn),
    .ctrl_i       (ctrl_m),
    .result_i     (result_m),
    .store_data_i (store_data_m),
    .rd_i         (rd_m),
    .pc_i         (pc_m),
    .fwd_m_o      (fwd_m),
    .wb_o         (wb)
  );

  // the register write of each cycle, straight off the writeback stage
  assign wb_o = wb;

endmodule

// ==== sim/cpu_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the five-stage core
// clock and reset, program loader, writeback compare, directed tests
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_tb;

  // cycles to wait for one register write
  localparam int WB_TIMEOUT  = 40;
  // quiet cycles checked once a program has spun down
  localparam int IDLE_CYCLES = 12;

  logic                    clk;
  logic                    resetn;
  logic                    imem_we_i;
  logic [`CPU_IMEM_AW-1:0] imem_addr_i;
  logic [`CPU_XLEN-1:0]    imem_data_i;
  cpu_pkg::wb_t            wb_o;

  // program image, copied into the core while reset is low
  logic [`CPU_XLEN-1:0] prog [0:`CPU_IMEM_DEPTH-1];
  logic [31:0]          rng;
  int                   errors;
  int                   timeouts;

  cpu u_cpu (
    .clk         (clk),
    .resetn      (resetn),
    .imem_we_i   (imem_we_i),
    .imem_addr_i (imem_addr_i),
    .imem_data_i (imem_data_i),
    .wb_o        (wb_o)
  );

  // 100 ns period
  always #50 clk = ~clk;

  //////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // imm8 is sign extended by decode
  function automatic logic [`CPU_XLEN-1:0] sext8(input logic [7:0] v);
    return {{(`CPU_XLEN-8){v[7]}}, v};
  endfunction

  function automatic cpu_pkg::inst_u dp_imm_word(
    input cpu_pkg::alu_op_e       op,
    input logic [`CPU_REG_AW-1:0] rd,
    input logic [`CPU_REG_AW-1:0] rn,
    input logic [7:0]             imm8
  );
    cpu_pkg::inst_u w;
    w             = '0;
    w.dp.cond     = 4'he;
    w.dp.imm_flag = 1'b1;
    w.dp.opcode   = op;
    w.dp.rn       = rn;
    w.dp.rd       = rd;
    w.dp.operand  = {4'h0, imm8};
    return w;
  endfunction

  function automatic cpu_pkg::inst_u dp_reg_word(
    input cpu_pkg::alu_op_e       op,
    input logic [`CPU_REG_AW-1:0] rd,
    input logic [`CPU_REG_AW-1:0] rn,
    input logic [`CPU_REG_AW-1:0] rm
  );
    cpu_pkg::inst_u w;
    w            = '0;
    w.dp.cond    = 4'he;
    w.dp.opcode  = op;
    w.dp.rn      = rn;
    w.dp.rd      = rd;
    w.dp.operand = {8'h00, rm};
    return w;
  endfunction

  // load when ld is set, store otherwise
  function automatic cpu_pkg::inst_u mem_word(
    input logic                   ld,
    input logic [`CPU_REG_AW-1:0] rd,
    input logic [`CPU_REG_AW-1:0] rn,
    input logic [11:0]            imm12
  );
    cpu_pkg::inst_u w;
    w           = '0;
    w.mem.cond  = 4'he;
    w.mem.cls   = 2'b01;
    w.mem.load  = ld;
    w.mem.rn    = rn;
    w.mem.rd    = rd;
    w.mem.imm12 = imm12;
    return w;
  endfunction

  function automatic cpu_pkg::inst_u branch_word(
    input logic [3:0]  cond,
    input logic        link,
    input logic [23:0] offset
  );
    cpu_pkg::inst_u w;
    w           = '0;
    w.br.cond   = cond;
    w.br.cls    = 3'b101;
    w.br.link   = link;
    w.br.offset = offset;
    return w;
  endfunction

  // every slot becomes a branch-always to itself
  task automatic clear_program();
    int idx;
    for (idx = 0; idx < `CPU_IMEM_DEPTH; idx++) begin
      prog[idx] = branch_word(4'he, 1'b0, 24'd0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////////

  task automatic check_wb(input cpu_pkg::wb_t got, input cpu_pkg::wb_t exp);
    if (got.addr !== exp.addr) begin
      $display("ERROR at %0t: wb_o.addr expected %0d, got %0d", $time, exp.addr, got.addr);
      errors++;
    end
    if (got.data !== exp.data) begin
      $display("ERROR at %0t: wb_o.data expected 0x%08h, got 0x%08h",
               $time, exp.data, got.data);
      errors++;
    end
  endtask

  task automatic check_idle(input cpu_pkg::wb_t got);
    if (got.valid !== 1'b0) begin
      $display("ERROR at %0t: wb_o.valid expected 0, got %b (r%0d = 0x%08h)",
               $time, got.valid, got.addr, got.data);
      errors++;
    end
  endtask

  // next register write, sampled mid-cycle
  task automatic expect_wb(input logic [`CPU_REG_AW-1:0] rd, input logic [`CPU_XLEN-1:0] data);
    cpu_pkg::wb_t exp;
    int           waited;
    exp.valid = 1'b1;
    exp.addr  = rd;
    exp.data  = data;
    waited    = 0;
    @(negedge clk);
    while (wb_o.valid !== 1'b1 && waited < WB_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (wb_o.valid !== 1'b1) begin
      $display("timeout at %0t: no register write within %0d cycles, expected r%0d = 0x%08h",
               $time, WB_TIMEOUT, rd, data);
      timeouts++;
    end else begin
      check_wb(wb_o, exp);
    end
  endtask

  task automatic expect_idle(input int cycles);
    int n;
    for (n = 0; n < cycles; n++) begin
      @(negedge clk);
      check_idle(wb_o);
    end
  endtask

  // reset low, copy the image, hold 10 more cycles, release
  task automatic boot_program();
    int idx;
    @(posedge clk);
    resetn <= 1'b0;
    for (idx = 0; idx < `CPU_IMEM_DEPTH; idx++) begin
      @(posedge clk);
      imem_we_i   <= 1'b1;
      imem_addr_i <= `CPU_IMEM_AW'(idx);
      imem_data_i <= prog[idx];
    end
    @(posedge clk);
    imem_we_i <= 1'b0;
    // nothing retires while reset is held
    expect_idle(10);
    @(posedge clk);
    resetn <= 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////////

  task automatic forward_chain();
    logic [7:0]           imm_a;
    logic [7:0]           imm_b;
    logic [`CPU_XLEN-1:0] r1;
    logic [`CPU_XLEN-1:0] r2;
    logic [`CPU_XLEN-1:0] r3;
    logic [`CPU_XLEN-1:0] r4;
    logic [`CPU_XLEN-1:0] r5;
    int                   round;
    for (round = 0; round < 3; round++) begin
      rng   = xorshift32(rng);
      imm_a = rng[7:0];
      rng   = xorshift32(rng);
      imm_b = rng[7:0];
      r1    = sext8(imm_a);
      r2    = 32'd0 - sext8(imm_b);
      r3    = r2 + r1;
      r4    = r3 + r1;
      r5    = r4 + r2;
      clear_program();
      prog[0] = dp_imm_word(cpu_pkg::ALU_ADD, 4'd1, 4'd0, imm_a);
      prog[1] = dp_imm_word(cpu_pkg::ALU_SUB, 4'd2, 4'd0, imm_b);
      // r2 one back from memory stage, r1 two back from writeback
      prog[2] = dp_reg_word(cpu_pkg::ALU_ADD, 4'd3, 4'd2, 4'd1);
      // r1 three back, caught by the register file write-through
      prog[3] = dp_reg_word(cpu_pkg::ALU_ADD, 4'd4, 4'd3, 4'd1);
      prog[4] = dp_reg_word(cpu_pkg::ALU_ADD, 4'd5, 4'd4, 4'd2);
      boot_program();
      expect_wb(4'd1, r1);
      expect_wb(4'd2, r2);
      expect_wb(4'd3, r3);
      expect_wb(4'd4, r4);
      expect_wb(4'd5, r5);
      expect_idle(IDLE_CYCLES);
    end
  endtask

  task automatic logic_ops();
    logic [`CPU_XLEN-1:0] opa;
    logic [`CPU_XLEN-1:0] opb;
    opa = sext8(8'hc6);
    opb = sext8(8'h5a);
    clear_program();
    prog[0] = dp_imm_word(cpu_pkg::ALU_MOV, 4'd1, 4'd0, 8'hc6);
    prog[1] = dp_imm_word(cpu_pkg::ALU_MOV, 4'd2, 4'd0, 8'h5a);
    prog[2] = dp_reg_word(cpu_pkg::ALU_AND, 4'd3, 4'd1, 4'd2);
    prog[3] = dp_reg_word(cpu_pkg::ALU_EOR, 4'd4, 4'd1, 4'd2);
    prog[4] = dp_reg_word(cpu_pkg::ALU_ORR, 4'd5, 4'd1, 4'd2);
    prog[5] = dp_reg_word(cpu_pkg::ALU_BIC, 4'd6, 4'd1, 4'd2);
    prog[6] = dp_reg_word(cpu_pkg::ALU_MVN, 4'd7, 4'd0, 4'd2);
    // reverse subtract, rm minus rn
    prog[7] = dp_reg_word(cpu_pkg::ALU_RSB, 4'd8, 4'd1, 4'd2);
    prog[8] = dp_reg_word(cpu_pkg::ALU_MOV, 4'd9, 4'd0, 4'd1);
    boot_program();
    expect_wb(4'd1, opa);
    expect_wb(4'd2, opb);
    expect_wb(4'd3, opa & opb);
    expect_wb(4'd4, opa ^ opb);
    expect_wb(4'd5, opa | opb);
    expect_wb(4'd6, opa & ~opb);
    expect_wb(4'd7, ~opb);
    expect_wb(4'd8, opb - opa);
    expect_wb(4'd9, opa);
    expect_idle(IDLE_CYCLES);
  endtask

  task automatic store_then_load();
    logic [`CPU_XLEN-1:0] val;
    val = sext8(8'ha7);
    clear_program();
    prog[0] = dp_imm_word(cpu_pkg::ALU_MOV, 4'd1, 4'd0, 8'ha7);
    prog[1] = dp_imm_word(cpu_pkg::ALU_MOV, 4'd2, 4'd0, 8'h10);
    // word at 0x14, store data r1 forwarded from writeback
    prog[2] = mem_word(1'b0, 4'd1, 4'd2, 12'd4);
    prog[3] = mem_word(1'b1, 4'd3, 4'd2, 12'd4);
    // load result used at once
    prog[4] = dp_imm_word(cpu_pkg::ALU_ADD, 4'd4, 4'd3, 8'd1);
    boot_program();
    expect_wb(4'd1, val);
    expect_wb(4'd2, 32'h0000_0010);
    expect_wb(4'd3, val);
    expect_wb(4'd4, val + 32'd1);
    expect_idle(IDLE_CYCLES);
  endtask

  task automatic branch_on_zero(input logic zero);
    logic [7:0] sub_imm;
    sub_imm = zero ? 8'd5 : 8'd4;
    clear_program();
    prog[0] = dp_imm_word(cpu_pkg::ALU_MOV, 4'd1, 4'd0, 8'd5);
    prog[1] = dp_imm_word(cpu_pkg::ALU_SUB, 4'd2, 4'd1, sub_imm);
    // BEQ to slot 5, slots 3 and 4 sit in its shadow
    prog[2] = branch_word(4'b0000, 1'b0, 24'd3);
    prog[3] = dp_imm_word(cpu_pkg::ALU_MOV, 4'd3, 4'd0, 8'd1);
    prog[4] = dp_imm_word(cpu_pkg::ALU_MOV, 4'd4, 4'd0, 8'd2);
    prog[5] = dp_imm_word(cpu_pkg::ALU_MOV, 4'd5, 4'd0, 8'd7);
    boot_program();
    expect_wb(4'd1, 32'd5);
    expect_wb(4'd2, 32'd5 - {24'd0, sub_imm});
    if (!zero) begin
      expect_wb(4'd3, 32'd1);
      expect_wb(4'd4, 32'd2);
    end
    expect_wb(4'd5, 32'd7);
    expect_idle(IDLE_CYCLES);
  endtask

  task automatic branch_with_link();
    clear_program();
    prog[0] = dp_imm_word(cpu_pkg::ALU_MOV, 4'd1, 4'd0, 8'd1);
    // BL at 0x4 to 0x10
    prog[1] = branch_word(4'he, 1'b1, 24'd3);
    prog[2] = dp_imm_word(cpu_pkg::ALU_MOV, 4'd2, 4'd0, 8'd2);
    prog[3] = dp_imm_word(cpu_pkg::ALU_MOV, 4'd3, 4'd0, 8'd3);
    prog[4] = dp_imm_word(cpu_pkg::ALU_MOV, 4'd4, 4'd0, 8'd4);
    boot_program();
    expect_wb(4'd1, 32'd1);
    expect_wb(`CPU_REG_AW'(`CPU_LINK_REG), 32'h0000_0004 + 32'd4);
    expect_wb(4'd4, 32'd4);
    expect_idle(IDLE_CYCLES);
  endtask

  initial begin
    clk         = 1'b0;
    resetn      = 1'b0;
    imem_we_i   = 1'b0;
    imem_addr_i = '0;
    imem_data_i = '0;
    rng         = 32'h7bc8;
    errors      = 0;
    timeouts    = 0;
    repeat (10) @(posedge clk);
    forward_chain();
    logic_ops();
    store_then_load();
    branch_on_zero(1'b1);
    branch_on_zero(1'b0);
    branch_with_link();
    $display("summary: %0d value errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== cpu.f ====
+incdir+src
src/cpu_pkg.sv
src/cpu_alu.sv
src/cpu_regfile.sv
src/cpu_fetch.sv
src/cpu_decode.sv
src/cpu_execute.sv
src/cpu_memory.sv
src/cpu.sv
sim/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the core and its testbench with Verilator, run, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module cpu_tb -f cpu.f -o cpu_tb_sim \
  && ./obj_dir/cpu_tb_sim | tee sim.log \
  || { echo "simulation build or run failed"; exit 1; }
grep -q "^Done: no errors$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
